// ==== canvas_pkg.sv ====
package canvas_pkg;

    // ==================================================================
    // Canvas geometry
    // ==================================================================
    localparam int CANVAS_W     = 160;
    localparam int CANVAS_H     = 120;
    localparam int CANVAS_CELLS = CANVAS_W * CANVAS_H;

    // ==================================================================
    // Coordinates and addresses
    // ==================================================================
    // Host side draws at twice the cell resolution
    typedef logic [$clog2(2 * CANVAS_W)-1:0] draw_x_t;
    typedef logic [$clog2(2 * CANVAS_H)-1:0] draw_y_t;

    typedef logic [$clog2(CANVAS_W)-1:0]     cell_x_t;
    typedef logic [$clog2(CANVAS_H)-1:0]     cell_y_t;

    // Row major, row times width plus column
    typedef logic [$clog2(CANVAS_CELLS)-1:0] cell_addr_t;

endpackage

// ==== shape_pkg.sv ====
package shape_pkg;

    typedef enum logic [2:0] {
        SHAPE_NONE      = 3'd0,
        SHAPE_RECTANGLE = 3'd1,
        SHAPE_SQUARE    = 3'd2,
        SHAPE_TRIANGLE  = 3'd3,
        SHAPE_CIRCLE    = 3'd4
    } shape_t;

    // Feature widths
    typedef logic [14:0] pixel_count_t;
    typedef logic [8:0]  extent_t;
    typedef logic [17:0] area_t;
    typedef logic [7:0]  confidence_t;

    // Fill ratio in 1/256 steps, 256 for a fully set box
    typedef logic [8:0]  fill_t;

    // ==================================================================
    // Fill thresholds
    // ==================================================================
    localparam fill_t FILL_TRI_MIN         = 9'd77;
    localparam fill_t FILL_TRI_IDEAL_LO    = 9'd102;
    localparam fill_t FILL_TRI_IDEAL_HI    = 9'd140;
    localparam fill_t FILL_TRI_MAX         = 9'd154;
    localparam fill_t FILL_CIRCLE_MIN      = 9'd170;
    localparam fill_t FILL_CIRCLE_NEAR_LO  = 9'd180;
    localparam fill_t FILL_CIRCLE_IDEAL_LO = 9'd190;
    localparam fill_t FILL_HIGH            = 9'd192;
    localparam fill_t FILL_GOOD            = 9'd204;
    localparam fill_t FILL_CIRCLE_IDEAL_HI = 9'd210;
    localparam fill_t FILL_CIRCLE_MAX      = 9'd220;
    localparam fill_t FILL_BEST            = 9'd230;

    // ==================================================================
    // Confidence scores
    // ==================================================================
    localparam confidence_t CONF_BOX_BEST    = 8'd255;
    localparam confidence_t CONF_CIRCLE_BEST = 8'd240;
    localparam confidence_t CONF_BOX_GOOD    = 8'd220;
    localparam confidence_t CONF_GOOD        = 8'd200;
    localparam confidence_t CONF_BOX_FAIR    = 8'd180;
    localparam confidence_t CONF_FAIR        = 8'd160;
    localparam confidence_t CONF_POOR        = 8'd120;

endpackage

// ==== canvas_read_if.sv ====
interface canvas_read_if;
    import canvas_pkg::*;

    logic    rd_en;
    cell_x_t rd_x;
    cell_y_t rd_y;
    // Valid one cycle after rd_en
    logic    rd_data;

    modport scanner (
        output rd_en, rd_x, rd_y,
        input  rd_data
    );

    modport store (
        input  rd_en, rd_x, rd_y,
        output rd_data
    );

endinterface

// ==== feature_if.sv ====
interface feature_if;
    import shape_pkg::*;

    // One cycle pulse, the rest hold until the next scan
    logic         valid;
    pixel_count_t pixel_count;
    extent_t      width;
    extent_t      height;
    logic         empty;

    modport scanner (
        output valid, pixel_count, width, height, empty
    );

    modport classifier (
        input  valid, pixel_count, width, height, empty
    );

endinterface

// ==== canvas_store.sv ====
module canvas_store #(
    parameter int CANVAS_W = canvas_pkg::CANVAS_W,
    parameter int CANVAS_H = canvas_pkg::CANVAS_H
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear_start,
    output logic                clearing,
    input  logic                wr_en,
    input  canvas_pkg::draw_x_t wr_x,
    input  canvas_pkg::draw_y_t wr_y,
    input  logic                wr_data,
    canvas_read_if.store        rd
);
    import canvas_pkg::*;

    localparam int CELL_COUNT = CANVAS_W * CANVAS_H;
    localparam cell_addr_t LAST_ADDR = cell_addr_t'(CELL_COUNT - 1);

    logic       canvas_mem [CELL_COUNT];
    cell_addr_t clear_addr;
    cell_x_t    wr_cell_x;
    cell_y_t    wr_cell_y;
    cell_addr_t wr_addr;
    cell_addr_t rd_addr;

    // Halve host coordinates down to cells
    assign wr_cell_x = cell_x_t'(wr_x >> 1);
    assign wr_cell_y = cell_y_t'(wr_y >> 1);

    assign wr_addr = cell_addr_t'(wr_cell_y) * cell_addr_t'(CANVAS_W)
                   + cell_addr_t'(wr_cell_x);
    assign rd_addr = cell_addr_t'(rd.rd_y) * cell_addr_t'(CANVAS_W)
                   + cell_addr_t'(rd.rd_x);

    // ==================================================================
    // Clear sweep, one cell per cycle
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            clearing   <= 1'b0;
            clear_addr <= '0;
        end else if (clearing) begin
            if (clear_addr == LAST_ADDR) begin
                clearing   <= 1'b0;
                clear_addr <= '0;
            end else begin
                clear_addr <= clear_addr + cell_addr_t'(1);
            end
        end else if (clear_start) begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end
    end

    // ==================================================================
    // Single port array: clear, then draw, then scan read
    // ==================================================================
    always_ff @(posedge clk) begin
        if (clearing) begin
            canvas_mem[clear_addr] <= 1'b0;
        end else if (wr_en) begin
            canvas_mem[wr_addr] <= wr_data;
        end else if (rd.rd_en) begin
            rd.rd_data <= canvas_mem[rd_addr];
        end
    end

    // The control machine never starts a scan during a sweep
    a_no_read_while_clearing : assert property (
        @(posedge clk) disable iff (!reset_n) !(rd.rd_en && clearing)
    );

endmodule

// ==== feature_scanner.sv ====
module feature_scanner #(
    parameter int CANVAS_W = canvas_pkg::CANVAS_W,
    parameter int CANVAS_H = canvas_pkg::CANVAS_H
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start,
    canvas_read_if.scanner rd,
    feature_if.scanner     feat
);
    import canvas_pkg::*;
    import shape_pkg::*;

    localparam cell_x_t LAST_X = cell_x_t'(CANVAS_W - 1);
    localparam cell_y_t LAST_Y = cell_y_t'(CANVAS_H - 1);

    logic         scanning;
    cell_x_t      scan_x;
    cell_y_t      scan_y;
    logic         last_cell;
    logic         d_valid;
    logic         d_last;
    cell_x_t      d_x;
    cell_y_t      d_y;
    logic         acc_done;
    pixel_count_t set_count;
    cell_x_t      min_x;
    cell_x_t      max_x;
    cell_y_t      min_y;
    cell_y_t      max_y;

    assign last_cell = (scan_x == LAST_X) && (scan_y == LAST_Y);

    assign rd.rd_en = scanning;
    assign rd.rd_x  = scan_x;
    assign rd.rd_y  = scan_y;

    // ==================================================================
    // Raster counter, one read per cycle
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            scanning <= 1'b0;
            scan_x   <= '0;
            scan_y   <= '0;
        end else if (scanning) begin
            if (scan_x == LAST_X) begin
                scan_x <= '0;
                if (scan_y == LAST_Y) begin
                    scanning <= 1'b0;
                end else begin
                    scan_y <= scan_y + cell_y_t'(1);
                end
            end else begin
                scan_x <= scan_x + cell_x_t'(1);
            end
        end else if (start) begin
            scanning <= 1'b1;
            scan_x   <= '0;
            scan_y   <= '0;
        end
    end

    // Coordinates follow the read by one cycle to meet rd_data
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            d_valid  <= 1'b0;
            d_last   <= 1'b0;
            acc_done <= 1'b0;
        end else begin
            d_valid  <= scanning;
            d_last   <= scanning && last_cell;
            acc_done <= d_valid && d_last;
        end
    end

    always_ff @(posedge clk) begin
        d_x <= scan_x;
        d_y <= scan_y;
    end

    // Count and bounding box
    always_ff @(posedge clk) begin
        if (start) begin
            set_count <= '0;
            min_x     <= LAST_X;
            max_x     <= '0;
            min_y     <= LAST_Y;
            max_y     <= '0;
        end else if (d_valid && rd.rd_data) begin
            set_count <= set_count + pixel_count_t'(1);
            if (d_x < min_x) min_x <= d_x;
            if (d_x > max_x) max_x <= d_x;
            if (d_y < min_y) min_y <= d_y;
            if (d_y > max_y) max_y <= d_y;
        end
    end

    // ==================================================================
    // Scan results
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            feat.valid <= 1'b0;
        end else begin
            feat.valid <= acc_done;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done) begin
            feat.pixel_count <= set_count;
            feat.empty       <= (set_count == '0);
            if (set_count == '0) begin
                feat.width  <= '0;
                feat.height <= '0;
            end else begin
                feat.width  <= extent_t'(max_x) - extent_t'(min_x) + extent_t'(1);
                feat.height <= extent_t'(max_y) - extent_t'(min_y) + extent_t'(1);
            end
        end
    end

    a_bbox_ordered : assert property (
        @(posedge clk) disable iff (!reset_n)
        feat.valid && !feat.empty |-> (min_x <= max_x) && (min_y <= max_y)
    );

endmodule

// ==== shape_classifier.sv ====
module shape_classifier (
    input  logic                    clk,
    input  logic                    reset_n,
    feature_if.classifier           feat,
    output logic                    recognition_done,
    output shape_pkg::shape_t       detected_shape,
    output shape_pkg::confidence_t  confidence
);
    import shape_pkg::*;

    localparam int NUM_W = $bits(pixel_count_t) + 8;

    logic               s1_valid;
    logic               s2_valid;
    logic               empty_done;
    pixel_count_t       lat_count;
    extent_t            lat_width;
    extent_t            lat_height;
    area_t              area;
    logic [NUM_W-1:0]   fill_num;
    logic [NUM_W-1:0]   fill_quot;
    fill_t              fill;
    extent_t            side_diff;
    extent_t            side_min;
    logic               square_aspect;
    shape_t             next_shape;
    confidence_t        next_conf;

    assign empty_done = feat.valid && feat.empty;

    // ==================================================================
    // Stage 1 latch, stage 2 fill ratio
    // ==================================================================
    assign area      = area_t'(lat_width) * area_t'(lat_height);
    assign fill_num  = {lat_count, 8'd0};
    assign fill_quot = fill_num / NUM_W'(area);

    always_ff @(posedge clk) begin
        if (feat.valid) begin
            lat_count  <= feat.pixel_count;
            lat_width  <= feat.width;
            lat_height <= feat.height;
        end
        if (s1_valid) begin
            fill <= fill_t'(fill_quot);
        end
    end

    // ==================================================================
    // Stage 3 aspect test and decision
    // ==================================================================
    always_comb begin
        if (lat_width > lat_height) begin
            side_diff = lat_width - lat_height;
            side_min  = lat_height;
        end else begin
            side_diff = lat_height - lat_width;
            side_min  = lat_width;
        end
        // Within one eighth of the short side
        square_aspect = side_diff < (side_min >> 3);

        if (fill >= FILL_HIGH) begin
            next_shape = square_aspect ? SHAPE_SQUARE : SHAPE_RECTANGLE;
            if (fill >= FILL_BEST)      next_conf = CONF_BOX_BEST;
            else if (fill >= FILL_GOOD) next_conf = CONF_BOX_GOOD;
            else                        next_conf = CONF_BOX_FAIR;
        end else if (square_aspect && fill >= FILL_CIRCLE_MIN && fill < FILL_CIRCLE_MAX) begin
            next_shape = SHAPE_CIRCLE;
            if (fill >= FILL_CIRCLE_IDEAL_LO && fill <= FILL_CIRCLE_IDEAL_HI) begin
                next_conf = CONF_CIRCLE_BEST;
            end else if (fill >= FILL_CIRCLE_NEAR_LO && fill <= FILL_CIRCLE_MAX) begin
                next_conf = CONF_GOOD;
            end else begin
                next_conf = CONF_FAIR;
            end
        end else begin
            next_shape = SHAPE_TRIANGLE;
            if (fill >= FILL_TRI_IDEAL_LO && fill <= FILL_TRI_IDEAL_HI) begin
                next_conf = CONF_GOOD;
            end else if (fill >= FILL_TRI_MIN && fill <= FILL_TRI_MAX) begin
                next_conf = CONF_FAIR;
            end else begin
                next_conf = CONF_POOR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s1_valid         <= 1'b0;
            s2_valid         <= 1'b0;
            recognition_done <= 1'b0;
            detected_shape   <= SHAPE_NONE;
            confidence       <= '0;
        end else begin
            s1_valid         <= feat.valid && !feat.empty;
            s2_valid         <= s1_valid;
            recognition_done <= empty_done || s2_valid;
            // Empty canvas finishes straight from stage 1
            if (empty_done) begin
                detected_shape <= SHAPE_NONE;
                confidence     <= '0;
            end else if (s2_valid) begin
                detected_shape <= next_shape;
                confidence     <= next_conf;
            end
        end
    end

    a_area_nonzero : assert property (
        @(posedge clk) disable iff (!reset_n)
        feat.valid && !feat.empty |-> (feat.width != '0) && (feat.height != '0)
    );

endmodule

// ==== shape_recognizer.sv ====
module shape_recognizer #(
    parameter int CANVAS_W = canvas_pkg::CANVAS_W,
    parameter int CANVAS_H = canvas_pkg::CANVAS_H
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   draw_en,
    input  canvas_pkg::draw_x_t    draw_x,
    input  canvas_pkg::draw_y_t    draw_y,
    input  logic                   draw_pixel_on,
    input  logic                   clear_canvas,
    input  logic                   start_recognition,
    output logic                   busy,
    output logic                   recognition_done,
    output shape_pkg::shape_t      detected_shape,
    output shape_pkg::confidence_t confidence
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ANALYZE,
        ST_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic        clearing;
    logic        clear_start;
    logic        scan_accept;
    logic        scan_start;
    logic        store_wr_en;

    canvas_read_if rd_bus ();
    feature_if     feat_bus ();

    // A clear wins over a start in the same cycle
    assign clear_start = (state == ST_IDLE) && clear_canvas && !clearing;
    assign scan_accept = (state == ST_IDLE) && start_recognition && !clearing && !clear_start;

    // Drawing only while idle
    assign store_wr_en = draw_en && (state == ST_IDLE);

    // ==================================================================
    // Recognition control
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= ST_IDLE;
            scan_start <= 1'b0;
            busy       <= 1'b0;
        end else begin
            scan_start <= scan_accept;
            busy       <= clearing || (state != ST_IDLE);
            case (state)
                ST_IDLE:    if (scan_accept) state <= ST_ANALYZE;
                ST_ANALYZE: if (recognition_done) state <= ST_DONE;
                ST_DONE:    if (!start_recognition) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    canvas_store #(
        .CANVAS_W (CANVAS_W),
        .CANVAS_H (CANVAS_H)
    ) canvas_store_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .clear_start (clear_start),
        .clearing    (clearing),
        .wr_en       (store_wr_en),
        .wr_x        (draw_x),
        .wr_y        (draw_y),
        .wr_data     (draw_pixel_on),
        .rd          (rd_bus.store)
    );

    feature_scanner #(
        .CANVAS_W (CANVAS_W),
        .CANVAS_H (CANVAS_H)
    ) feature_scanner_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (scan_start),
        .rd      (rd_bus.scanner),
        .feat    (feat_bus.scanner)
    );

    shape_classifier shape_classifier_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .feat             (feat_bus.classifier),
        .recognition_done (recognition_done),
        .detected_shape   (detected_shape),
        .confidence       (confidence)
    );

endmodule

// ==== shape_recognizer_tb.sv ====
module shape_recognizer_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import shape_pkg::*;

    localparam int TIMEOUT = 25000;
    // Stray cell far from every drawn shape
    localparam int STRAY_X = 150;
    localparam int STRAY_Y = 110;

    logic                clk;
    logic                reset_n;
    logic                draw_en;
    canvas_pkg::draw_x_t draw_x;
    canvas_pkg::draw_y_t draw_y;
    logic                draw_pixel_on;
    logic                clear_canvas;
    logic                start_recognition;
    logic                busy;
    logic                recognition_done;
    shape_t              detected_shape;
    confidence_t         confidence;

    int errors;
    bit timed_out;

    shape_recognizer shape_recognizer_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .draw_en           (draw_en),
        .draw_x            (draw_x),
        .draw_y            (draw_y),
        .draw_pixel_on     (draw_pixel_on),
        .clear_canvas      (clear_canvas),
        .start_recognition (start_recognition),
        .busy              (busy),
        .recognition_done  (recognition_done),
        .detected_shape    (detected_shape),
        .confidence        (confidence)
    );

    always #5 clk = ~clk;

    // ==================================================================
    // Checks and waits
    // ==================================================================
    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic wait_busy(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== level) begin
            $display("Timeout at %0t ns: busy did not go to %0b within %0d cycles",
                     $time, level, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (recognition_done !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (recognition_done !== 1'b1) begin
            $display("Timeout at %0t ns: recognition_done never pulsed within %0d cycles",
                     $time, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // ==================================================================
    // Drawing, host coordinates are twice the cell coordinates
    // ==================================================================
    task automatic draw_cell(input int cx, input int cy);
        @(posedge clk);
        draw_en       <= 1'b1;
        draw_pixel_on <= 1'b1;
        draw_x        <= canvas_pkg::draw_x_t'(2 * cx);
        draw_y        <= canvas_pkg::draw_y_t'(2 * cy);
    endtask

    task automatic end_draw();
        @(posedge clk);
        draw_en <= 1'b0;
    endtask

    task automatic draw_rect(input int x0, input int y0, input int w, input int h);
        int r;
        int c;
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                draw_cell(x0 + c, y0 + r);
            end
        end
        end_draw();
    endtask

    // Right angle at the top left, row r holds w*(h-r)/h cells
    task automatic draw_triangle(input int x0, input int y0, input int w, input int h);
        int r;
        int c;
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                if (c * h < w * (h - r)) draw_cell(x0 + c, y0 + r);
            end
        end
        end_draw();
    endtask

    task automatic draw_disc(input int cx, input int cy, input int rad);
        int dx;
        int dy;
        for (dy = -rad; dy <= rad; dy++) begin
            for (dx = -rad; dx <= rad; dx++) begin
                if (dx * dx + dy * dy <= rad * rad) draw_cell(cx + dx, cy + dy);
            end
        end
        end_draw();
    endtask

    task automatic wipe_canvas();
        @(posedge clk);
        clear_canvas <= 1'b1;
        @(posedge clk);
        clear_canvas <= 1'b0;
        wait_busy(1'b1);
        if (timed_out) return;
        wait_busy(1'b0);
    endtask

    // Start held past done, busy must hold until it drops
    task automatic recognize(input bit stray_draws, output int shape, output int conf);
        int i;
        shape = -1;
        conf  = -1;
        @(posedge clk);
        start_recognition <= 1'b1;
        wait_busy(1'b1);
        if (timed_out) return;
        if (stray_draws) begin
            for (i = 0; i < 4; i++) begin
                draw_cell(STRAY_X, STRAY_Y - i);
            end
            end_draw();
        end
        wait_done();
        if (timed_out) return;
        shape = int'(detected_shape);
        conf  = int'(confidence);
        repeat (3) begin
            @(negedge clk);
            check_value("busy", int'(busy), 1);
        end
        @(posedge clk);
        start_recognition <= 1'b0;
        wait_busy(1'b0);
    endtask

    function automatic string op_name(input int op);
        case (op)
            0:       return "clear";
            1:       return "rectangle";
            2:       return "triangle";
            3:       return "disc";
            default: return "unknown";
        endcase
    endfunction

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int    fd;
        int    n;
        int    op;
        int    x0;
        int    y0;
        int    p1;
        int    p2;
        int    stray;
        int    exp_shape;
        int    exp_conf;
        int    got_shape;
        int    got_conf;
        int    case_num;
        int    passed;
        int    failed;
        int    errors_before;
        string line;

        clk               = 1'b0;
        reset_n           = 1'b0;
        draw_en           = 1'b0;
        draw_x            = '0;
        draw_y            = '0;
        draw_pixel_on     = 1'b0;
        clear_canvas      = 1'b0;
        start_recognition = 1'b0;
        errors            = 0;
        timed_out         = 1'b0;
        case_num          = 0;
        passed            = 0;
        failed            = 0;

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("busy", int'(busy), 0);
        check_value("recognition_done", int'(recognition_done), 0);
        check_value("detected_shape", int'(detected_shape), int'(SHAPE_NONE));
        check_value("confidence", int'(confidence), 0);
        if (errors == 0) begin
            passed++;
            $display("test 0 reset: passed");
        end else begin
            failed++;
            $display("test 0 reset: failed");
        end

        fd = $fopen("shape_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open shape_cases.txt for reading");
            errors++;
        end

        while (fd != 0 && !$feof(fd) && !timed_out) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %d %d %d %d %d %d %d",
                            op, x0, y0, p1, p2, stray, exp_shape, exp_conf) == 8) begin
                    case_num++;
                    errors_before = errors;
                    case (op)
                        0: wipe_canvas();
                        1: draw_rect(x0, y0, p1, p2);
                        2: draw_triangle(x0, y0, p1, p2);
                        3: draw_disc(x0, y0, p1);
                        default: begin
                            $display("Unknown operation %0d in case %0d", op, case_num);
                            errors++;
                        end
                    endcase
                    if (!timed_out) recognize(stray != 0, got_shape, got_conf);
                    if (!timed_out) begin
                        check_value("detected_shape", got_shape, exp_shape);
                        check_value("confidence", got_conf, exp_conf);
                    end
                    if (errors == errors_before && !timed_out) begin
                        passed++;
                        $display("test %0d %s: passed", case_num, op_name(op));
                    end else begin
                        failed++;
                        $display("test %0d %s: failed", case_num, op_name(op));
                    end
                end
            end
        end
        if (fd != 0) $fclose(fd);

        $display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
        if (errors == 0 && !timed_out && case_num > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== shape_cases.txt ====
# op x y a b stray shape conf, all decimal, cell coordinates
# op 0 clear, 1 rectangle x y w h, 2 right triangle x y w h, 3 disc cx cy r
# stray 1 draws extra cells while busy, shape 0 none 1 rect 2 square 3 tri 4 circle
0 0 0 0 0 0 0 0           # empty canvas
1 20 20 40 40 0 2 255     # 40x40 block
0 0 0 0 0 0 0 0
1 10 50 60 20 1 1 255     # 60x20 block, draws while busy
0 0 0 0 0 0 0 0
2 30 30 40 40 0 3 200     # fill 131
0 0 0 0 0 0 0 0
2 20 20 60 20 1 3 200     # fill 134, draws while busy
0 0 0 0 0 0 0 0
3 80 60 20 0 1 4 240      # 1257 cells in 41x41, fill 191
0 0 0 0 0 0 0 0
3 40 40 10 0 0 4 200      # 317 cells in 21x21, fill 184
0 0 0 0 0 0 0 0
1 100 70 40 40 0 2 255    # redraw after clear

// ==== shape_recognizer.f ====
canvas_pkg.sv
shape_pkg.sv
canvas_read_if.sv
feature_if.sv
canvas_store.sv
feature_scanner.sv
shape_classifier.sv
shape_recognizer.sv
shape_recognizer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= shape_recognizer_tb
FILELIST  ?= shape_recognizer.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
